//--- logic/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// datapath and issue width
`define CORE_XLEN        32
`define CORE_NUM_LANES   2
`define CORE_REG_ADDR_W  5

// instruction buffer entries, power of two
`define CORE_BUF_DEPTH   8

// instruction word layout
`define CORE_INSTR_W     32
`define CORE_OP_MSB      31
`define CORE_OP_LSB      29
`define CORE_RD_LSB      24
`define CORE_RS1_LSB     19
`define CORE_RS2_LSB     14
`define CORE_IMM_W       14

`define CORE_SHAMT_W     5

`endif

//--- logic/core_pkg.sv
`default_nettype none
`include "core_macros.svh"

package core_pkg;

  typedef enum logic [`CORE_OP_MSB-`CORE_OP_LSB:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_OR  = 3'd3,
    OP_XOR = 3'd4,
    OP_SLL = 3'd5,
    OP_SRL = 3'd6,
    // rd <= sign-extended imm, no register read
    OP_LI  = 3'd7
  } op_e;

  typedef logic [`CORE_NUM_LANES-1:0] lane_mask_t;

endpackage

`default_nettype wire

//--- logic/instr_buffer.sv
`default_nettype none
`include "core_macros.svh"

module instr_buffer (
  input  wire                        aclk,
  input  wire                        rst_n,
  input  wire  [`CORE_NUM_LANES-1:0] push_valid,
  input  wire  [`CORE_INSTR_W-1:0]   push_instr [`CORE_NUM_LANES],
  input  wire  [1:0]                 pop_count,
  output logic [`CORE_NUM_LANES-1:0] head_valid,
  output logic [`CORE_INSTR_W-1:0]   head_instr [`CORE_NUM_LANES],
  output logic                       buf_ready
);

  localparam int PTR_W = $clog2(`CORE_BUF_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  logic [`CORE_INSTR_W-1:0] mem [`CORE_BUF_DEPTH];
  logic [PTR_W-1:0]         wr_ptr;
  logic [PTR_W-1:0]         wr_ptr_nx;
  logic [PTR_W-1:0]         rd_ptr;
  logic [PTR_W-1:0]         rd_ptr_nx;
  logic [CNT_W-1:0]         count;
  logic                     push_ok;
  logic [1:0]               push_num;

  // pointers wrap on their own, depth is a power of two
  assign wr_ptr_nx = wr_ptr + 1'b1;
  assign rd_ptr_nx = rd_ptr + 1'b1;

  // a push needs room for a full pair, even a single one
  assign buf_ready = (count <= CNT_W'(`CORE_BUF_DEPTH - 2));
  assign push_ok   = push_valid[0] & buf_ready;
  assign push_num  = push_ok ? (push_valid[1] ? 2'd2 : 2'd1) : 2'd0;

  always_ff @(posedge aclk) begin
    if (push_ok) begin
      mem[wr_ptr] <= push_instr[0];
      if (push_valid[1]) begin
        mem[wr_ptr_nx] <= push_instr[1];
      end
    end
  end

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      wr_ptr <= wr_ptr + PTR_W'(push_num);
      rd_ptr <= rd_ptr + PTR_W'(pop_count);
      count  <= count + CNT_W'(push_num) - CNT_W'(pop_count);
    end
  end

  // two oldest entries, lane 0 is the older one
  assign head_valid[0] = (count != '0);
  assign head_valid[1] = (count > CNT_W'(1));
  assign head_instr[0] = mem[rd_ptr];
  assign head_instr[1] = mem[rd_ptr_nx];

endmodule

`default_nettype wire

//--- logic/issue_unit.sv
`default_nettype none
`include "core_macros.svh"

module issue_unit (
  input  wire  [`CORE_NUM_LANES-1:0]  head_valid,
  input  wire  [`CORE_INSTR_W-1:0]    head_instr [`CORE_NUM_LANES],
  input  wire  [`CORE_XLEN-1:0]       rd_data    [2*`CORE_NUM_LANES],
  input  wire  core_pkg::lane_mask_t  res_valid,
  input  wire  [`CORE_REG_ADDR_W-1:0] res_rd     [`CORE_NUM_LANES],
  input  wire  [`CORE_XLEN-1:0]       res_data   [`CORE_NUM_LANES],
  output logic [1:0]                  pop_count,
  output logic [`CORE_REG_ADDR_W-1:0] rd_addr    [2*`CORE_NUM_LANES],
  output core_pkg::lane_mask_t        issue_valid,
  output core_pkg::op_e               issue_op   [`CORE_NUM_LANES],
  output logic [`CORE_REG_ADDR_W-1:0] issue_rd   [`CORE_NUM_LANES],
  output logic [`CORE_XLEN-1:0]       issue_a    [`CORE_NUM_LANES],
  output logic [`CORE_XLEN-1:0]       issue_b    [`CORE_NUM_LANES]
);

  core_pkg::op_e               op      [`CORE_NUM_LANES];
  logic [`CORE_REG_ADDR_W-1:0] rd      [`CORE_NUM_LANES];
  logic [`CORE_REG_ADDR_W-1:0] rs1     [`CORE_NUM_LANES];
  logic [`CORE_REG_ADDR_W-1:0] rs2     [`CORE_NUM_LANES];
  logic [`CORE_XLEN-1:0]       imm     [`CORE_NUM_LANES];
  logic [`CORE_XLEN-1:0]       src_val [2*`CORE_NUM_LANES];
  logic                        pair_dep;

  for (genvar i = 0; i < `CORE_NUM_LANES; i++) begin : g_dec
    assign op[i]  = core_pkg::op_e'(head_instr[i][`CORE_OP_MSB:`CORE_OP_LSB]);
    assign rd[i]  = head_instr[i][`CORE_RD_LSB +: `CORE_REG_ADDR_W];
    assign rs1[i] = head_instr[i][`CORE_RS1_LSB +: `CORE_REG_ADDR_W];
    assign rs2[i] = head_instr[i][`CORE_RS2_LSB +: `CORE_REG_ADDR_W];
    assign imm[i] = {{(`CORE_XLEN - `CORE_IMM_W){head_instr[i][`CORE_IMM_W-1]}},
                     head_instr[i][`CORE_IMM_W-1:0]};

    // ports 2i and 2i+1 belong to lane i
    assign rd_addr[2*i]   = rs1[i];
    assign rd_addr[2*i+1] = rs2[i];

    assign issue_op[i] = op[i];
    assign issue_rd[i] = rd[i];
    assign issue_a[i]  = (op[i] == core_pkg::OP_LI) ? imm[i] : src_val[2*i];
    assign issue_b[i]  = (op[i] == core_pkg::OP_LI) ? '0 : src_val[2*i+1];
  end

  // lane registers hold the results not yet in the register file
  always_comb begin
    for (int p = 0; p < 2*`CORE_NUM_LANES; p++) begin
      src_val[p] = rd_data[p];
      // higher lane is younger, so it overrides
      for (int l = 0; l < `CORE_NUM_LANES; l++) begin
        if (res_valid[l] && (res_rd[l] == rd_addr[p])) begin
          src_val[p] = res_data[l];
        end
      end
      if (rd_addr[p] == '0) begin
        src_val[p] = '0;
      end
    end
  end

  // second instruction reads what the first one writes
  assign pair_dep = (op[1] != core_pkg::OP_LI) && (rd[0] != '0) &&
                    ((rs1[1] == rd[0]) || (rs2[1] == rd[0]));

  assign issue_valid[0] = head_valid[0];
  assign issue_valid[1] = head_valid[1] & ~pair_dep;

  assign pop_count = 2'(issue_valid[0]) + 2'(issue_valid[1]);

endmodule

`default_nettype wire

//--- logic/reg_file.sv
`default_nettype none
`include "core_macros.svh"

module reg_file (
  input  wire                         aclk,
  input  wire                         rst_n,
  input  wire  [`CORE_REG_ADDR_W-1:0] rd_addr [2*`CORE_NUM_LANES],
  input  wire  [`CORE_NUM_LANES-1:0]  wr_en,
  input  wire  [`CORE_REG_ADDR_W-1:0] wr_addr [`CORE_NUM_LANES],
  input  wire  [`CORE_XLEN-1:0]       wr_data [`CORE_NUM_LANES],
  output logic [`CORE_XLEN-1:0]       rd_data [2*`CORE_NUM_LANES]
);

  localparam int NUM_REGS = 1 << `CORE_REG_ADDR_W;

  // r0 has no storage
  logic [`CORE_XLEN-1:0] regs [1:NUM_REGS-1];

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 1; r < NUM_REGS; r++) begin
        regs[r] <= '0;
      end
    end else begin
      // later port wins on the same register
      for (int w = 0; w < `CORE_NUM_LANES; w++) begin
        if (wr_en[w] && (wr_addr[w] != '0)) begin
          regs[wr_addr[w]] <= wr_data[w];
        end
      end
    end
  end

  always_comb begin
    for (int p = 0; p < 2*`CORE_NUM_LANES; p++) begin
      rd_data[p] = (rd_addr[p] == '0) ? '0 : regs[rd_addr[p]];
    end
  end

endmodule

`default_nettype wire

//--- logic/exec_lane.sv
`default_nettype none
`include "core_macros.svh"

module exec_lane (
  input  wire                         aclk,
  input  wire                         rst_n,
  input  wire                         issue_valid,
  input  wire  core_pkg::op_e         issue_op,
  input  wire  [`CORE_REG_ADDR_W-1:0] issue_rd,
  input  wire  [`CORE_XLEN-1:0]       issue_a,
  input  wire  [`CORE_XLEN-1:0]       issue_b,
  output logic                        res_valid,
  output logic [`CORE_REG_ADDR_W-1:0] res_rd,
  output logic [`CORE_XLEN-1:0]       res_data
);

  logic [`CORE_SHAMT_W-1:0] shamt;
  logic [`CORE_XLEN-1:0]    alu_out;

  assign shamt = issue_b[`CORE_SHAMT_W-1:0];

  always_comb begin
    case (issue_op)
      core_pkg::OP_ADD: alu_out = issue_a + issue_b;
      core_pkg::OP_SUB: alu_out = issue_a - issue_b;
      core_pkg::OP_AND: alu_out = issue_a & issue_b;
      core_pkg::OP_OR:  alu_out = issue_a | issue_b;
      core_pkg::OP_XOR: alu_out = issue_a ^ issue_b;
      core_pkg::OP_SLL: alu_out = issue_a << shamt;
      // logical, zero fill
      core_pkg::OP_SRL: alu_out = issue_a >> shamt;
      core_pkg::OP_LI:  alu_out = issue_a;
      default:          alu_out = '0;
    endcase
  end

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= issue_valid;
    end
  end

  always_ff @(posedge aclk) begin
    res_rd   <= issue_rd;
    res_data <= alu_out;
  end

endmodule

`default_nettype wire

//--- logic/writeback_unit.sv
`default_nettype none
`include "core_macros.svh"

module writeback_unit (
  input  wire                         aclk,
  input  wire                         rst_n,
  input  wire  core_pkg::lane_mask_t  res_valid,
  input  wire  [`CORE_REG_ADDR_W-1:0] res_rd      [`CORE_NUM_LANES],
  input  wire  [`CORE_XLEN-1:0]       res_data    [`CORE_NUM_LANES],
  output core_pkg::lane_mask_t        wr_en,
  output logic [`CORE_REG_ADDR_W-1:0] wr_addr     [`CORE_NUM_LANES],
  output logic [`CORE_XLEN-1:0]       wr_data     [`CORE_NUM_LANES],
  output core_pkg::lane_mask_t        retire_valid,
  output logic [`CORE_REG_ADDR_W-1:0] retire_rd   [`CORE_NUM_LANES],
  output logic [`CORE_XLEN-1:0]       retire_data [`CORE_NUM_LANES]
);

  // drop a write that a younger lane overwrites this cycle
  always_comb begin
    for (int i = 0; i < `CORE_NUM_LANES; i++) begin
      wr_en[i] = res_valid[i] && (res_rd[i] != '0);
      for (int j = i + 1; j < `CORE_NUM_LANES; j++) begin
        if (res_valid[j] && (res_rd[j] == res_rd[i])) begin
          wr_en[i] = 1'b0;
        end
      end
    end
  end

  assign wr_addr = res_rd;
  assign wr_data = res_data;

  // every result retires, r0 targets included
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      retire_valid <= '0;
    end else begin
      retire_valid <= res_valid;
    end
  end

  always_ff @(posedge aclk) begin
    retire_rd   <= res_rd;
    retire_data <= res_data;
  end

endmodule

`default_nettype wire

//--- logic/dual_issue_core.sv
`default_nettype none
`include "core_macros.svh"

module dual_issue_core (
  input  wire                         aclk,
  input  wire                         rst_n,
  input  wire  [`CORE_NUM_LANES-1:0]  push_valid,
  input  wire  [`CORE_INSTR_W-1:0]    push_instr  [`CORE_NUM_LANES],
  output logic                        buf_ready,
  output core_pkg::lane_mask_t        retire_valid,
  output logic [`CORE_REG_ADDR_W-1:0] retire_rd   [`CORE_NUM_LANES],
  output logic [`CORE_XLEN-1:0]       retire_data [`CORE_NUM_LANES]
);

  logic [`CORE_NUM_LANES-1:0]  head_valid;
  logic [`CORE_INSTR_W-1:0]    head_instr  [`CORE_NUM_LANES];
  logic [1:0]                  pop_count;
  logic [`CORE_REG_ADDR_W-1:0] rd_addr     [2*`CORE_NUM_LANES];
  logic [`CORE_XLEN-1:0]       rd_data     [2*`CORE_NUM_LANES];
  core_pkg::lane_mask_t        issue_valid;
  core_pkg::op_e               issue_op    [`CORE_NUM_LANES];
  logic [`CORE_REG_ADDR_W-1:0] issue_rd    [`CORE_NUM_LANES];
  logic [`CORE_XLEN-1:0]       issue_a     [`CORE_NUM_LANES];
  logic [`CORE_XLEN-1:0]       issue_b     [`CORE_NUM_LANES];
  core_pkg::lane_mask_t        res_valid;
  logic [`CORE_REG_ADDR_W-1:0] res_rd      [`CORE_NUM_LANES];
  logic [`CORE_XLEN-1:0]       res_data    [`CORE_NUM_LANES];
  core_pkg::lane_mask_t        wr_en;
  logic [`CORE_REG_ADDR_W-1:0] wr_addr     [`CORE_NUM_LANES];
  logic [`CORE_XLEN-1:0]       wr_data     [`CORE_NUM_LANES];

  instr_buffer u_buf (
    .aclk       (aclk),
    .rst_n      (rst_n),
    .push_valid (push_valid),
    .push_instr (push_instr),
    .pop_count  (pop_count),
    .head_valid (head_valid),
    .head_instr (head_instr),
    .buf_ready  (buf_ready)
  );

  issue_unit u_issue (
    .head_valid  (head_valid),
    .head_instr  (head_instr),
    .rd_data     (rd_data),
    .res_valid   (res_valid),
    .res_rd      (res_rd),
    .res_data    (res_data),
    .pop_count   (pop_count),
    .rd_addr     (rd_addr),
    .issue_valid (issue_valid),
    .issue_op    (issue_op),
    .issue_rd    (issue_rd),
    .issue_a     (issue_a),
    .issue_b     (issue_b)
  );

  reg_file u_rf (
    .aclk    (aclk),
    .rst_n   (rst_n),
    .rd_addr (rd_addr),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_data (rd_data)
  );

  for (genvar i = 0; i < `CORE_NUM_LANES; i++) begin : g_lane
    exec_lane u_lane (
      .aclk        (aclk),
      .rst_n       (rst_n),
      .issue_valid (issue_valid[i]),
      .issue_op    (issue_op[i]),
      .issue_rd    (issue_rd[i]),
      .issue_a     (issue_a[i]),
      .issue_b     (issue_b[i]),
      .res_valid   (res_valid[i]),
      .res_rd      (res_rd[i]),
      .res_data    (res_data[i])
    );
  end

  writeback_unit u_wb (
    .aclk         (aclk),
    .rst_n        (rst_n),
    .res_valid    (res_valid),
    .res_rd       (res_rd),
    .res_data     (res_data),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data)
  );

endmodule

`default_nettype wire

//--- verification/core_tb.sv
`default_nettype none
`include "core_macros.svh"

module core_tb;
  timeunit 1ns;
  timeprecision 1ps;

  // instructions per test section, burst is an upper bound
  localparam int N_INSTR = 30 + 64 + 24 + 32 + 32 + 96;
  // reset cycles on top of four per instruction plus slack
  localparam int MAX_CYCLES = 4 * N_INSTR + 200 + 16;

  logic                        aclk;
  logic                        rst_n;
  logic [`CORE_NUM_LANES-1:0]  push_valid;
  logic [`CORE_INSTR_W-1:0]    push_instr  [`CORE_NUM_LANES];
  logic                        buf_ready;
  core_pkg::lane_mask_t        retire_valid;
  logic [`CORE_REG_ADDR_W-1:0] retire_rd   [`CORE_NUM_LANES];
  logic [`CORE_XLEN-1:0]       retire_data [`CORE_NUM_LANES];

  logic [`CORE_XLEN-1:0]       model_regs  [32];
  logic [`CORE_REG_ADDR_W-1:0] exp_rd      [$];
  logic [`CORE_XLEN-1:0]       exp_data    [$];
  int                          cycles;
  int                          seed_val;

  dual_issue_core u_dut (
    .aclk         (aclk),
    .rst_n        (rst_n),
    .push_valid   (push_valid),
    .push_instr   (push_instr),
    .buf_ready    (buf_ready),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data)
  );

  initial begin
    aclk = 1'b0;
    forever #4 aclk = ~aclk;
  end

  function automatic logic [`CORE_INSTR_W-1:0] encode(input logic [2:0] op,
      input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2,
      input logic [`CORE_IMM_W-1:0] imm);
    logic [`CORE_INSTR_W-1:0] instr;
    instr = '0;
    instr[`CORE_OP_MSB:`CORE_OP_LSB] = op;
    instr[`CORE_RD_LSB +: 5] = rd;
    instr[`CORE_RS1_LSB +: 5] = rs1;
    instr[`CORE_RS2_LSB +: 5] = rs2;
    instr[`CORE_IMM_W-1:0] = imm;
    return instr;
  endfunction

  function automatic logic [4:0] rand_reg();
    return 5'($urandom_range(31, 1));
  endfunction

  function automatic logic [`CORE_INSTR_W-1:0] rand_instr(input logic [2:0] op,
      input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
    return encode(op, rd, rs1, rs2, `CORE_IMM_W'($urandom));
  endfunction

  // expected result straight from the instruction set rules
  function automatic logic [`CORE_XLEN-1:0] ref_result(input logic [`CORE_INSTR_W-1:0] instr,
      input logic [`CORE_XLEN-1:0] regs [32]);
    logic [`CORE_XLEN-1:0] a;
    logic [`CORE_XLEN-1:0] b;
    a = regs[instr[`CORE_RS1_LSB +: 5]];
    b = regs[instr[`CORE_RS2_LSB +: 5]];
    case (core_pkg::op_e'(instr[`CORE_OP_MSB:`CORE_OP_LSB]))
      core_pkg::OP_ADD: return a + b;
      core_pkg::OP_SUB: return a - b;
      core_pkg::OP_AND: return a & b;
      core_pkg::OP_OR:  return a | b;
      core_pkg::OP_XOR: return a ^ b;
      core_pkg::OP_SLL: return a << b[4:0];
      core_pkg::OP_SRL: return a >> b[4:0];
      default: return {{(`CORE_XLEN - `CORE_IMM_W){instr[`CORE_IMM_W-1]}},
                       instr[`CORE_IMM_W-1:0]};
    endcase
  endfunction

  task automatic apply_model(input logic [`CORE_INSTR_W-1:0] instr);
    logic [`CORE_XLEN-1:0] res;
    logic [4:0]            rd;
    res = ref_result(instr, model_regs);
    rd  = instr[`CORE_RD_LSB +: 5];
    exp_rd.push_back(rd);
    exp_data.push_back(res);
    if (rd != 5'd0) begin
      model_regs[rd] = res;
    end
  endtask

  // waits for room, then presents one or two instructions for one edge
  task automatic push_instrs(input logic [`CORE_INSTR_W-1:0] i0,
      input logic [`CORE_INSTR_W-1:0] i1, input bit two);
    @(negedge aclk);
    while (!buf_ready) begin
      push_valid = '0;
      @(negedge aclk);
    end
    push_instr[0] = i0;
    push_instr[1] = i1;
    push_valid    = two ? 2'b11 : 2'b01;
    apply_model(i0);
    if (two) begin
      apply_model(i1);
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
      input logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAIL at %0t: %s expected %h, actual %h", $time, name, expected, actual);
      $display("ERRORS FOUND");
      $fatal(1, "value mismatch");
    end
  endtask

  // retire outputs settled during the previous cycle
  always @(posedge aclk) begin : check_retire
    logic [4:0]            e_rd;
    logic [`CORE_XLEN-1:0] e_data;
    for (int l = 0; l < `CORE_NUM_LANES; l++) begin
      if (retire_valid[l]) begin
        if (exp_rd.size() == 0) begin
          $display("lane %0d retired an instruction that was never pushed", l);
          $display("ERRORS FOUND");
          $fatal(1, "unexpected retire");
        end else begin
          e_rd   = exp_rd.pop_front();
          e_data = exp_data.pop_front();
          check_value($sformatf("retire_rd[%0d]", l), 32'(e_rd), 32'(retire_rd[l]));
          check_value($sformatf("retire_data[%0d]", l), e_data, retire_data[l]);
        end
      end
    end
  end

  initial begin
    cycles = 0;
    forever begin
      @(posedge aclk);
      cycles++;
      if (cycles >= MAX_CYCLES) begin
        $display("pipeline stalled, %0d retires still outstanding", exp_rd.size());
        $display("ERRORS FOUND");
        $fatal(1, "timeout");
      end
    end
  end

  initial begin : stimulus
    logic [4:0] d;
    logic [4:0] e;
    logic [4:0] prev;
    logic [4:0] nxt;
    seed_val   = $urandom(32'h82aa);
    rst_n      = 1'b0;
    push_valid = '0;
    push_instr[0] = '0;
    push_instr[1] = '0;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    repeat (16) @(posedge aclk);
    @(negedge aclk);
    rst_n = 1'b1;

    // idle after reset
    repeat (3) @(negedge aclk);
    check_value("buf_ready", 32'd1, 32'(buf_ready));
    check_value("retire_valid", 32'd0, 32'(retire_valid));

    for (int i = 0; i < 15; i++) begin
      push_instrs(rand_instr(core_pkg::OP_LI, 5'(2*i+1), 5'd0, 5'd0),
                  rand_instr(core_pkg::OP_LI, 5'(2*i+2), 5'd0, 5'd0), 1'b1);
    end

    // independent pairs, lane 0 writes r1..r15, lane 1 works in r16..r31
    for (int i = 0; i < 32; i++) begin
      push_instrs(rand_instr(3'(i), 5'($urandom_range(15, 1)), rand_reg(), rand_reg()),
                  rand_instr(3'(i + 3), 5'($urandom_range(31, 16)),
                             5'($urandom_range(31, 16)), 5'($urandom_range(31, 16))), 1'b1);
    end

    // chains of single pushes
    for (int c = 0; c < 4; c++) begin
      prev = rand_reg();
      push_instrs(rand_instr(core_pkg::OP_LI, prev, 5'd0, 5'd0), '0, 1'b0);
      for (int k = 0; k < 5; k++) begin
        nxt = rand_reg();
        push_instrs(rand_instr(3'($urandom_range(6, 0)), nxt, prev, rand_reg()), '0, 1'b0);
        prev = nxt;
      end
    end

    // second instruction depends on the first
    for (int i = 0; i < 16; i++) begin
      d = rand_reg();
      push_instrs(rand_instr(3'($urandom), d, rand_reg(), rand_reg()),
                  rand_instr(3'($urandom_range(6, 0)), rand_reg(), d, rand_reg()), 1'b1);
    end

    // same destination in a pair, then writes to r0 and reads of r0
    for (int i = 0; i < 8; i++) begin
      d = rand_reg();
      e = rand_reg();
      // lane 0 reads r0 while the previous r0 result sits in the lane registers
      push_instrs(rand_instr(3'($urandom_range(6, 0)), d, 5'd0, rand_reg()),
                  rand_instr(3'($urandom), d, rand_reg(), rand_reg()), 1'b1);
      push_instrs(rand_instr(3'($urandom), 5'd0, rand_reg(), rand_reg()),
                  rand_instr(3'($urandom_range(6, 0)), e, d, 5'd0), 1'b1);
    end

    // bursts against buf_ready
    for (int i = 0; i < 48; i++) begin
      push_instrs(rand_instr(3'($urandom), 5'($urandom), 5'($urandom), 5'($urandom)),
                  rand_instr(3'($urandom), 5'($urandom), 5'($urandom), 5'($urandom)),
                  ($urandom_range(3, 0) != 0));
    end

    @(negedge aclk);
    push_valid = '0;
    while (exp_rd.size() != 0) begin
      @(negedge aclk);
    end
    repeat (4) @(negedge aclk);
    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+logic
logic/core_pkg.sv
logic/instr_buffer.sv
logic/issue_unit.sv
logic/reg_file.sv
logic/exec_lane.sv
logic/writeback_unit.sv
logic/dual_issue_core.sv
verification/core_tb.sv
